//--- compile.f
+incdir+hdl
hdl/rvm_pkg.sv
hdl/rvm_wb_port.sv
hdl/rvm_decode.sv
hdl/rvm_regfile.sv
hdl/rvm_exec.sv
hdl/rvm_top.sv
tests/rvm_asserts.sv
tests/rvm_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rvm testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rvm_tb -o rvm_sim -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rvm_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

//--- tests/rvm_tb.sv
`timescale 1ns/100ps
`include "rvm_consts.svh"

module rvm_tb;
    localparam int N_RR       = 120;
    localparam int N_IMM      = 256;   // 8 immediate ops times 32 shift amounts
    localparam int N_UPPER    = 32;
    localparam int N_ILLEGAL  = 32;
    localparam int N_INST     = N_RR + N_IMM + N_UPPER + N_ILLEGAL + 4;
    localparam int MAX_CYCLES = N_INST * 40 + 2000;

    // {alt, funct3} of add sub sll slt sltu xor srl sra or and
    localparam logic [3:0] RR_OPS [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                           4'h4, 4'h5, 4'hd, 4'h6, 4'h7};

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    integer      seed;
    int          cycles = 0;
    logic [31:0] regs_m [32];   // reference register file
    logic [31:0] pc_m;
    logic        flag_m;
    logic [15:0] count_m;

    rvm_top rvm_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run went past %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    // mostly random with the odd corner value
    function automatic logic [31:0] rnd_operand();
        logic [31:0] r;
        r = rnd32();
        if (r[1:0] != 2'b00)
            return rnd32();
        case (r[3:2])
            2'd0:    return 32'h8000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        logic       lt;
        sh = b[4:0];
        lt = (a[31] != b[31]) ? a[31] : (a < b);   // signed compare from the sign bits
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, lt};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] illegal_word();
        logic [31:0] w;
        logic [31:0] r;
        w = rnd32();
        r = rnd32();
        case (r[2:0])
            3'd0: w[6:0] = 7'b0000011;   // load
            3'd1: w[6:0] = 7'b0100011;   // store
            3'd2: w[6:0] = 7'b1100011;   // branch
            3'd3: w[6:0] = 7'b1101111;   // jal
            3'd4: w[6:0] = 7'b1110011;   // system
            3'd5: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = 7'b0000001;   // M extension
            end
            3'd6: begin
                w[6:0]   = 7'b0010011;
                w[14:12] = 3'b001;
                w[31:25] = 7'b0100000;   // slli with a bad funct7
            end
            default: w[6:0] = 7'b0000000;
        endcase
        return w;
    endfunction

    function automatic logic [7:0] reg_adr(input logic [4:0] idx);
        return `RVM_ADR_REG_BASE | {1'b0, idx, 2'b00};
    endfunction

    // request held through the ack edge and dropped after it
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        logic [31:0] gap;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
        rdat = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        gap = rnd32();
        if (gap[1:0] == 2'b00)
            @(negedge clk);   // idle bus cycle now and then
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
        wb_write(reg_adr(idx), val);
        if (idx != 5'd0)
            regs_m[idx] = val;
    endtask

    task automatic check_reg(input logic [4:0] idx);
        logic [31:0] d;
        wb_read(reg_adr(idx), d);
        check_value($sformatf("x%0d", idx), regs_m[idx], d);
    endtask

    task automatic check_status();
        logic [31:0] d;
        wb_read(`RVM_ADR_STATUS, d);
        check_value("status", {flag_m, 15'b0, count_m}, d);
    endtask

    task automatic retire(input logic [4:0] rd, input logic [31:0] res);
        if (rd != 5'd0)
            regs_m[rd] = res;
        count_m = count_m + 16'd1;
    endtask

    task automatic run_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] res;
        res = alu_model(f3, alt, regs_m[rs1], regs_m[rs2]);
        wb_write(`RVM_ADR_INST, {alt ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, 7'b0110011});
        retire(rd, res);
    endtask

    task automatic run_i(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                         input logic [4:0] rs1);
        logic [31:0] res;
        logic        alt;
        alt = (f3 == 3'b101) && imm[10];   // srai marker in imm[11:5]
        res = alu_model(f3, alt, regs_m[rs1], {{20{imm[11]}}, imm});
        wb_write(`RVM_ADR_INST, {imm, rs1, f3, rd, 7'b0010011});
        retire(rd, res);
    endtask

    task automatic run_u(input logic auipc, input logic [19:0] uimm, input logic [4:0] rd);
        logic [31:0] res;
        res = auipc ? pc_m + {uimm, 12'b0} : {uimm, 12'b0};
        wb_write(`RVM_ADR_INST, {uimm, rd, auipc ? 7'b0010111 : 7'b0110111});
        retire(rd, res);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  k;
        seed     = 32'hb24ea81a;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 8'h0;
        wb_dat_w = 32'h0;
        regs_m   = '{default: '0};
        pc_m     = 32'h0;
        flag_m   = 1'b0;
        count_m  = 16'h0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // register-register ops
        for (int i = 0; i < N_RR; i++) begin
            r   = rnd32();
            rs1 = r[4:0];
            rs2 = r[9:5];
            rd  = r[14:10];
            k   = 4'(r[31:16] % 16'd10);
            set_reg(rs1, rnd_operand());
            set_reg(rs2, rnd_operand());
            {alt, f3} = RR_OPS[k];
            run_r(f3, alt, rd, rs1, rs2);
            check_reg(rd);
        end

        // immediate ops with every shift amount for each shift
        for (int i = 0; i < N_IMM; i++) begin
            r  = rnd32();
            f3 = i[2:0];
            case (f3)
                3'b001:  imm = {7'b0, i[7:3]};
                3'b101:  imm = {r[20] ? 7'b0100000 : 7'b0, i[7:3]};
                default: imm = {i[3], r[10:0]};   // negative every other round
            endcase
            rs1 = r[15:11];
            rd  = r[25:21];
            set_reg(rs1, rnd_operand());
            run_i(f3, imm, rd, rs1);
            check_reg(rd);
        end
        check_status();

        // lui and auipc against fresh pc values
        for (int i = 0; i < N_UPPER; i++) begin
            r    = rnd32();
            pc_m = {r[31:2], 2'b00};
            wb_write(`RVM_ADR_PC, pc_m);
            wb_read(`RVM_ADR_PC, d);
            check_value("pc", pc_m, d);
            r = rnd32();
            run_u(i[0], r[31:12], r[4:0]);
            check_reg(r[4:0]);
        end

        // x0 stays zero
        set_reg(5'd0, 32'hdead_beef);
        check_reg(5'd0);
        set_reg(5'd1, rnd_operand());
        run_i(3'b000, 12'h7ff, 5'd0, 5'd1);
        check_reg(5'd0);
        run_r(3'b110, 1'b0, 5'd0, 5'd1, 5'd1);
        check_reg(5'd0);
        run_u(1'b0, 20'hfffff, 5'd0);
        check_reg(5'd0);
        run_u(1'b1, 20'h12345, 5'd0);
        check_reg(5'd0);
        check_status();

        // illegal words touch nothing but the flag
        for (int i = 0; i < N_ILLEGAL; i++) begin
            wb_write(`RVM_ADR_INST, illegal_word());
            flag_m = 1'b1;
            if (i % 8 == 7)
                check_status();
        end
        for (int i = 0; i < 32; i++)
            check_reg(5'(i));
        wb_write(`RVM_ADR_STATUS, 32'h0);   // clears the sticky flag
        flag_m = 1'b0;
        check_status();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- tests/rvm_asserts.sv
`timescale 1ns/100ps

module rvm_asserts (
    input logic             clk,
    input logic             rst,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_ack,
    input logic             busy,
    input rvm_pkg::rvm_wb_t wb_res
);

    ack_with_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack high without an active request");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held longer than one cycle");

    // decode valid blocks the next ack
    no_ack_when_busy: assert property (@(posedge clk) disable iff (rst)
        busy |=> !wb_ack)
        else $error("wb_ack raised while an instruction was in flight");

    // one instruction in flight, so each writeback is a single pulse
    one_writeback: assert property (@(posedge clk) disable iff (rst)
        wb_res.done |=> !wb_res.done)
        else $error("writeback lasted more than one cycle");

endmodule

bind rvm_top rvm_asserts rvm_asserts_i (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .busy   (busy),
    .wb_res (wb_res)
);

//--- hdl/rvm_top.sv
`timescale 1ns/100ps
`include "rvm_consts.svh"

module rvm_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`RVM_ADR_W-1:0]   wb_adr,
    input  logic [`RVM_XLEN-1:0]    wb_dat_w,
    output logic [`RVM_XLEN-1:0]    wb_dat_r,
    output logic                    wb_ack
);
    import rvm_pkg::*;

    rvm_dec_t               dec;
    rvm_wb_t                wb_res;
    logic                   busy;
    logic                   issue;
    logic [`RVM_XLEN-1:0]   issue_inst;
    logic [`RVM_XLEN-1:0]   issue_pc;
    logic [`RVM_REG_AW-1:0] rs1_addr;
    logic [`RVM_REG_AW-1:0] rs2_addr;
    logic [`RVM_XLEN-1:0]   rs1_data;
    logic [`RVM_XLEN-1:0]   rs2_data;
    logic [`RVM_REG_AW-1:0] host_addr;
    logic                   host_we;
    logic [`RVM_XLEN-1:0]   host_wdata;
    logic [`RVM_XLEN-1:0]   host_rdata;

    assign busy = dec.valid;   // hold off the bus while an instruction is in flight

    rvm_wb_port rvm_wb_port_i (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .busy       (busy),
        .wb_res     (wb_res),
        .host_rdata (host_rdata),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .issue      (issue),
        .issue_inst (issue_inst),
        .issue_pc   (issue_pc),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata)
    );

    rvm_decode rvm_decode_i (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issue_inst (issue_inst),
        .issue_pc   (issue_pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .dec        (dec)
    );

    rvm_regfile rvm_regfile_i (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .wb_res     (wb_res),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .host_rdata (host_rdata)
    );

    rvm_exec rvm_exec_i (
        .dec        (dec),
        .wb_res     (wb_res)
    );

endmodule

//--- hdl/rvm_exec.sv
`timescale 1ns/100ps
`include "rvm_consts.svh"

module rvm_exec (
    input  rvm_pkg::rvm_dec_t   dec,
    output rvm_pkg::rvm_wb_t    wb_res
);
    import rvm_pkg::*;

    logic                   use_imm;
    logic                   illegal;
    logic [`RVM_XLEN-1:0]   a;
    logic [`RVM_XLEN-1:0]   b;
    logic [4:0]             shamt;
    logic [`RVM_XLEN-1:0]   result;

    // immediate forms take imm as the second operand
    always_comb begin
        case (dec.op)
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
            OP_SLLI, OP_SRAI, OP_SRLI,
            OP_SLTI, OP_SLTIU: use_imm = 1'b1;
            default:           use_imm = 1'b0;
        endcase
    end

    assign a       = dec.rs1_data;
    assign b       = use_imm ? dec.imm : dec.rs2_data;
    assign shamt   = b[4:0];
    assign illegal = (dec.op == OP_ILLEGAL);

    always_comb begin
        case (dec.op)
            OP_ADD, OP_ADDI:   result = a + b;
            OP_SUB:            result = a - b;
            OP_AND, OP_ANDI:   result = a & b;
            OP_OR, OP_ORI:     result = a | b;
            OP_XOR, OP_XORI:   result = a ^ b;
            OP_SLL, OP_SLLI:   result = a << shamt;
            OP_SRL, OP_SRLI:   result = a >> shamt;
            OP_SRA, OP_SRAI:   result = $signed(a) >>> shamt;   // keep sign bit
            OP_SLT, OP_SLTI: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            OP_SLTU, OP_SLTIU: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            OP_LUI:            result = dec.imm;
            OP_AUIPC:          result = dec.pc + dec.imm;
            default:           result = '0;
        endcase
    end

    // an illegal word still completes, it just writes nothing
    always_comb begin
        wb_res.done    = dec.valid;
        wb_res.we      = dec.valid & ~illegal;
        wb_res.rd      = dec.rd;
        wb_res.data    = result;
        wb_res.illegal = dec.valid & illegal;
    end

endmodule

//--- hdl/rvm_regfile.sv
`timescale 1ns/100ps
`include "rvm_consts.svh"

module rvm_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`RVM_REG_AW-1:0]  rs1_addr,
    input  logic [`RVM_REG_AW-1:0]  rs2_addr,
    input  logic [`RVM_REG_AW-1:0]  host_addr,
    input  logic                    host_we,
    input  logic [`RVM_XLEN-1:0]    host_wdata,
    input  rvm_pkg::rvm_wb_t        wb_res,
    output logic [`RVM_XLEN-1:0]    rs1_data,
    output logic [`RVM_XLEN-1:0]    rs2_data,
    output logic [`RVM_XLEN-1:0]    host_rdata
);
    logic [`RVM_XLEN-1:0] regs [`RVM_NREGS];
    logic                 wb_write;

    assign wb_write = wb_res.done && wb_res.we && (wb_res.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RVM_NREGS; i++)
                regs[i] <= '0;
        end else begin
            // host and writeback never fire in the same cycle
            if (host_we && host_addr != '0)
                regs[host_addr] <= host_wdata;
            if (wb_write)
                regs[wb_res.rd] <= wb_res.data;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rs1_data   = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data   = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign host_rdata = (host_addr == '0) ? '0 : regs[host_addr];

endmodule

//--- hdl/rvm_decode.sv
`timescale 1ns/100ps
`include "rvm_consts.svh"

module rvm_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  logic [`RVM_XLEN-1:0]    issue_inst,
    input  logic [`RVM_XLEN-1:0]    issue_pc,
    input  logic [`RVM_XLEN-1:0]    rs1_data,
    input  logic [`RVM_XLEN-1:0]    rs2_data,
    output logic [`RVM_REG_AW-1:0]  rs1_addr,
    output logic [`RVM_REG_AW-1:0]  rs2_addr,
    output rvm_pkg::rvm_dec_t       dec
);
    import rvm_pkg::*;

    logic [16:0]            pattern;
    rvm_op_e                op_next;
    logic [`RVM_XLEN-1:0]   imm_next;
    logic                   is_upper;

    // opcode, funct3, funct7 in one word for the pattern match
    assign pattern = {issue_inst[6:0], issue_inst[14:12], issue_inst[31:25]};

    function automatic rvm_op_e match_op(input logic [16:0] p);
        casez (p)
            17'b0110011_000_0000000: match_op = OP_ADD;
            17'b0010011_000_???????: match_op = OP_ADDI;
            17'b0110011_000_0100000: match_op = OP_SUB;
            17'b0110011_111_0000000: match_op = OP_AND;
            17'b0010011_111_???????: match_op = OP_ANDI;
            17'b0110011_110_0000000: match_op = OP_OR;
            17'b0010011_110_???????: match_op = OP_ORI;
            17'b0110011_100_0000000: match_op = OP_XOR;
            17'b0010011_100_???????: match_op = OP_XORI;
            17'b0110011_001_0000000: match_op = OP_SLL;
            17'b0010011_001_0000000: match_op = OP_SLLI;
            17'b0110011_101_0100000: match_op = OP_SRA;
            17'b0010011_101_0100000: match_op = OP_SRAI;
            17'b0110011_101_0000000: match_op = OP_SRL;
            17'b0010011_101_0000000: match_op = OP_SRLI;
            17'b0110111_???_???????: match_op = OP_LUI;
            17'b0010111_???_???????: match_op = OP_AUIPC;
            17'b0110011_010_0000000: match_op = OP_SLT;
            17'b0110011_011_0000000: match_op = OP_SLTU;
            17'b0010011_010_???????: match_op = OP_SLTI;
            17'b0010011_011_???????: match_op = OP_SLTIU;
            default:                 match_op = OP_ILLEGAL;
        endcase
    endfunction

    assign op_next  = match_op(pattern);
    assign is_upper = (op_next == OP_LUI) || (op_next == OP_AUIPC);

    // shift immediates keep shamt in imm[4:0], same field as I-type
    assign imm_next = is_upper ? {issue_inst[31:12], 12'b0}
                               : {{20{issue_inst[31]}}, issue_inst[31:20]};

    // operand read straight from the issue word
    assign rs1_addr = issue_inst[19:15];
    assign rs2_addr = issue_inst[24:20];

    always_ff @(posedge clk) begin
        if (rst)
            dec.valid <= 1'b0;
        else
            dec.valid <= issue;   // issue is a single pulse, so valid lasts one cycle
        if (issue) begin
            dec.op       <= op_next;
            dec.rd       <= issue_inst[11:7];
            dec.rs1_data <= rs1_data;
            dec.rs2_data <= rs2_data;
            dec.imm      <= imm_next;
            dec.pc       <= issue_pc;
            dec.inst     <= issue_inst;
        end
    end

endmodule

//--- hdl/rvm_wb_port.sv
`timescale 1ns/100ps
`include "rvm_consts.svh"

module rvm_wb_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`RVM_ADR_W-1:0]   wb_adr,
    input  logic [`RVM_XLEN-1:0]    wb_dat_w,
    input  logic                    busy,
    input  rvm_pkg::rvm_wb_t        wb_res,
    input  logic [`RVM_XLEN-1:0]    host_rdata,
    output logic                    wb_ack,
    output logic [`RVM_XLEN-1:0]    wb_dat_r,
    output logic                    issue,
    output logic [`RVM_XLEN-1:0]    issue_inst,
    output logic [`RVM_XLEN-1:0]    issue_pc,
    output logic [`RVM_REG_AW-1:0]  host_addr,
    output logic                    host_we,
    output logic [`RVM_XLEN-1:0]    host_wdata
);
    logic                   accept;
    logic                   in_window;
    logic                   wr_inst;
    logic                   wr_pc;
    logic                   wr_status;
    logic [`RVM_XLEN-1:0]   pc;
    logic                   illegal_flag;
    logic [`RVM_CNT_W-1:0]  retired;
    logic [`RVM_XLEN-1:0]   status;

    // request is taken on the edge that raises ack, never twice
    assign accept    = wb_cyc & wb_stb & ~wb_ack & ~busy;
    assign in_window = wb_adr >= `RVM_ADR_REG_BASE;
    assign wr_inst   = accept & wb_we & (wb_adr == `RVM_ADR_INST);
    assign wr_pc     = accept & wb_we & (wb_adr == `RVM_ADR_PC);
    assign wr_status = accept & wb_we & (wb_adr == `RVM_ADR_STATUS);

    assign host_addr  = wb_adr[`RVM_REG_AW+1:2];   // word index inside the window
    assign host_we    = accept & wb_we & in_window;
    assign host_wdata = wb_dat_w;
    assign issue_pc   = pc;   // stable until decode has captured it

    assign status = {illegal_flag, {(`RVM_XLEN-1-`RVM_CNT_W){1'b0}}, retired};

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            issue  <= 1'b0;
        end else begin
            wb_ack <= accept;
            issue  <= wr_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_inst)
            issue_inst <= wb_dat_w;
        if (accept && !wb_we) begin
            if (in_window) begin
                wb_dat_r <= host_rdata;
            end else begin
                case (wb_adr)
                    `RVM_ADR_INST:   wb_dat_r <= issue_inst;   // last issued word
                    `RVM_ADR_PC:     wb_dat_r <= pc;
                    `RVM_ADR_STATUS: wb_dat_r <= status;
                    default:         wb_dat_r <= '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= '0;
            illegal_flag <= 1'b0;
            retired      <= '0;
        end else begin
            if (wr_pc)
                pc <= wb_dat_w;
            if (wr_status)
                illegal_flag <= 1'b0;   // any STATUS write clears
            else if (wb_res.done && wb_res.illegal)
                illegal_flag <= 1'b1;
            if (wb_res.done && !wb_res.illegal)
                retired <= retired + 1'b1;
        end
    end

endmodule

//--- hdl/rvm_pkg.sv
`include "rvm_consts.svh"

package rvm_pkg;

    // one entry per accepted instruction pattern
    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDI,
        OP_SUB,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_SLL,
        OP_SLLI,
        OP_SRA,
        OP_SRAI,
        OP_SRL,
        OP_SRLI,
        OP_LUI,
        OP_AUIPC,
        OP_SLT,
        OP_SLTU,
        OP_SLTI,
        OP_SLTIU,
        OP_ILLEGAL
    } rvm_op_e;

    // decode register contents
    typedef struct packed {
        logic                       valid;
        rvm_op_e                    op;
        logic [`RVM_REG_AW-1:0]     rd;
        logic [`RVM_XLEN-1:0]       rs1_data;
        logic [`RVM_XLEN-1:0]       rs2_data;
        logic [`RVM_XLEN-1:0]       imm;       // sign extended, or upper imm in place
        logic [`RVM_XLEN-1:0]       pc;
        logic [`RVM_XLEN-1:0]       inst;
    } rvm_dec_t;

    // result of one instruction
    typedef struct packed {
        logic                       done;
        logic                       we;
        logic [`RVM_REG_AW-1:0]     rd;
        logic [`RVM_XLEN-1:0]       data;
        logic                       illegal;
    } rvm_wb_t;

endpackage

//--- hdl/rvm_consts.svh
`ifndef RVM_CONSTS_SVH
`define RVM_CONSTS_SVH

// datapath and register file
`define RVM_XLEN        32
`define RVM_NREGS       32
`define RVM_REG_AW      5

// retired instruction counter, lower half of STATUS
`define RVM_CNT_W       16

// wishbone byte address width
`define RVM_ADR_W       8

// register map, word aligned
`define RVM_ADR_INST        8'h00
`define RVM_ADR_PC          8'h04
`define RVM_ADR_STATUS      8'h08
`define RVM_ADR_REG_BASE    8'h80   // x0 at 0x80 up to x31 at 0xfc

// STATUS layout
`define RVM_STAT_ILLEGAL    31

`endif
